// ==== rtl/bft_cfg.svh ====
`ifndef BFT_CFG_SVH
`define BFT_CFG_SVH

// leaf count of the fat tree
`define BFT_NUM_LEAVES 8

// leaf address width, log2 of the leaf count
`define BFT_ADDR_W 3

// packet data width
`define BFT_PAYLOAD_W 8

// switch levels, root is level 0
`define BFT_LEVELS 3

`endif

// ==== rtl/bft_pkg.sv ====
`include "bft_cfg.svh"

package bft_pkg;

	// destination or source leaf number
	typedef logic [`BFT_ADDR_W-1:0] leaf_addr_t;

	// packet data carried along with the address
	typedef logic [`BFT_PAYLOAD_W-1:0] payload_t;

	// desired direction of a packet, or the source picked for an output
	// the encoding matches the switch port numbering
	typedef enum logic [1:0] {
		ROUTE_VOID  = 2'b00,
		ROUTE_LEFT  = 2'b01,
		ROUTE_RIGHT = 2'b10,
		ROUTE_UP    = 2'b11
	} route_t;

endpackage

// ==== rtl/tree_link_if.sv ====
`timescale 1ns/100ps

interface tree_link_if import bft_pkg::*; ();

	// toward the leaves
	logic       down_valid;
	leaf_addr_t down_dest;
	payload_t   down_payload;

	// toward the root
	logic       up_valid;
	leaf_addr_t up_dest;
	payload_t   up_payload;

	modport parent (
		output down_valid,
		output down_dest,
		output down_payload,
		input  up_valid,
		input  up_dest,
		input  up_payload
	);

	modport child (
		input  down_valid,
		input  down_dest,
		input  down_payload,
		output up_valid,
		output up_dest,
		output up_payload
	);

endinterface

// ==== rtl/t_arbiter.sv ====
`timescale 1ns/100ps

module t_arbiter import bft_pkg::*; #(
	parameter bit ROOT = 1'b0
) (
	input  route_t d_l_i,
	input  route_t d_r_i,
	input  route_t d_u_i,
	output route_t sel_l_o,
	output route_t sel_r_o,
	output route_t sel_u_o
);

	generate
		if (ROOT) begin : g_root
			// no up port here, packets either turn back or swap sides
			always_comb begin
				sel_l_o = ROUTE_VOID;
				sel_r_o = ROUTE_VOID;
				sel_u_o = ROUTE_VOID;
				if (d_l_i == ROUTE_LEFT)
					sel_l_o = ROUTE_LEFT;
				if (d_r_i == ROUTE_RIGHT)
					sel_r_o = ROUTE_RIGHT;
				// right packet crossing over, or bounced back if left is taken
				if (d_r_i == ROUTE_LEFT) begin
					if (sel_l_o == ROUTE_VOID)
						sel_l_o = ROUTE_RIGHT;
					else
						sel_r_o = ROUTE_RIGHT;
				end
				if (d_l_i == ROUTE_RIGHT) begin
					if (sel_r_o == ROUTE_VOID)
						sel_r_o = ROUTE_LEFT;
					else
						sel_l_o = ROUTE_LEFT;
				end
			end
		end else begin : g_tree
			always_comb begin
				sel_l_o = ROUTE_VOID;
				sel_r_o = ROUTE_VOID;
				sel_u_o = ROUTE_VOID;

				// turnback first
				if (d_l_i == ROUTE_LEFT)
					sel_l_o = ROUTE_LEFT;
				if (d_r_i == ROUTE_RIGHT)
					sel_r_o = ROUTE_RIGHT;

				// downlink next, bounced back up when its bus is taken
				if (d_u_i == ROUTE_UP)
					sel_u_o = ROUTE_UP;
				else if (d_u_i == ROUTE_LEFT) begin
					if (d_l_i != ROUTE_LEFT)
						sel_l_o = ROUTE_UP;
					else
						sel_u_o = ROUTE_UP;
				end else if (d_u_i == ROUTE_RIGHT) begin
					if (d_r_i != ROUTE_RIGHT)
						sel_r_o = ROUTE_UP;
					else
						sel_u_o = ROUTE_UP;
				end

				// left input, side link before uplink
				if (d_l_i == ROUTE_RIGHT) begin
					if (sel_r_o == ROUTE_VOID)
						sel_r_o = ROUTE_LEFT;
					else if (d_u_i == ROUTE_LEFT)
						sel_u_o = ROUTE_LEFT;
					else
						sel_l_o = ROUTE_LEFT;
				end else if (d_l_i == ROUTE_UP) begin
					if (sel_u_o == ROUTE_VOID)
						sel_u_o = ROUTE_LEFT;
					else if (sel_l_o == ROUTE_VOID)
						sel_l_o = ROUTE_LEFT;
					else
						sel_r_o = ROUTE_LEFT;
				end

				// right input takes whatever is still free
				if (d_r_i == ROUTE_LEFT) begin
					if (sel_l_o == ROUTE_VOID)
						sel_l_o = ROUTE_RIGHT;
					else if (sel_r_o == ROUTE_VOID)
						sel_r_o = ROUTE_RIGHT;
					else
						sel_u_o = ROUTE_RIGHT;
				end else if (d_r_i == ROUTE_UP) begin
					if (sel_u_o == ROUTE_VOID)
						sel_u_o = ROUTE_RIGHT;
					else if (sel_r_o == ROUTE_VOID)
						sel_r_o = ROUTE_RIGHT;
					else
						sel_l_o = ROUTE_RIGHT;
				end
			end
		end
	endgenerate

	// each valid input leaves on exactly one output, an idle input on none
	always_comb begin
		assert final ($countones({sel_l_o == ROUTE_LEFT, sel_r_o == ROUTE_LEFT,
			sel_u_o == ROUTE_LEFT}) == (d_l_i != ROUTE_VOID))
			else $error("left input lost or duplicated in %m");
		assert final ($countones({sel_l_o == ROUTE_RIGHT, sel_r_o == ROUTE_RIGHT,
			sel_u_o == ROUTE_RIGHT}) == (d_r_i != ROUTE_VOID))
			else $error("right input lost or duplicated in %m");
		assert final ($countones({sel_l_o == ROUTE_UP, sel_r_o == ROUTE_UP,
			sel_u_o == ROUTE_UP}) == (d_u_i != ROUTE_VOID))
			else $error("up input lost or duplicated in %m");
	end

endmodule

// ==== rtl/t_switch.sv ====
`timescale 1ns/100ps
`include "bft_cfg.svh"

module t_switch import bft_pkg::*; #(
	parameter int unsigned LEVEL     = 0,
	parameter int unsigned NODE_ADDR = 0
) (
	input logic         clk,
	input logic         reset,
	tree_link_if.child  parent_link,
	tree_link_if.parent left_link,
	tree_link_if.parent right_link
);

	localparam int PKT_W        = 1 + `BFT_ADDR_W + `BFT_PAYLOAD_W;
	localparam int PREFIX_SHIFT = `BFT_ADDR_W - LEVEL;
	localparam int TURN_BIT     = `BFT_ADDR_W - 1 - LEVEL;

	logic [PKT_W-1:0] in_l;
	logic [PKT_W-1:0] in_r;
	logic [PKT_W-1:0] in_u;
	logic [PKT_W-1:0] out_l;
	logic [PKT_W-1:0] out_r;
	logic [PKT_W-1:0] out_u;
	logic             u_valid;
	route_t           d_l;
	route_t           d_r;
	route_t           d_u;
	route_t           sel_l;
	route_t           sel_r;
	route_t           sel_u;

	// down when this node's subtree holds the destination, up otherwise
	function automatic route_t decide(input logic valid, input leaf_addr_t dest);
		route_t d;
		if (!valid)
			d = ROUTE_VOID;
		else if ((dest >> PREFIX_SHIFT) != leaf_addr_t'(NODE_ADDR))
			d = ROUTE_UP;
		else if (dest[TURN_BIT])
			d = ROUTE_RIGHT;
		else
			d = ROUTE_LEFT;
		return d;
	endfunction

	function automatic logic [PKT_W-1:0] pick(
		input route_t           sel,
		input logic [PKT_W-1:0] l,
		input logic [PKT_W-1:0] r,
		input logic [PKT_W-1:0] u
	);
		logic [PKT_W-1:0] w;
		case (sel)
			ROUTE_LEFT:  w = l;
			ROUTE_RIGHT: w = r;
			ROUTE_UP:    w = u;
			default:     w = '0;
		endcase
		return w;
	endfunction

	// the root has nothing above it
	assign u_valid = (LEVEL == 0) ? 1'b0 : parent_link.down_valid;

	assign in_l = {left_link.up_valid, left_link.up_dest, left_link.up_payload};
	assign in_r = {right_link.up_valid, right_link.up_dest, right_link.up_payload};
	assign in_u = {u_valid, parent_link.down_dest, parent_link.down_payload};

	assign d_l = decide(left_link.up_valid, left_link.up_dest);
	assign d_r = decide(right_link.up_valid, right_link.up_dest);
	assign d_u = decide(u_valid, parent_link.down_dest);

	t_arbiter #(
		.ROOT (LEVEL == 0)
	) arb_i (
		.d_l_i   (d_l),
		.d_r_i   (d_r),
		.d_u_i   (d_u),
		.sel_l_o (sel_l),
		.sel_r_o (sel_r),
		.sel_u_o (sel_u)
	);

	// one register stage, unselected outputs go idle
	always_ff @(posedge clk) begin
		if (reset) begin
			out_l <= '0;
			out_r <= '0;
			out_u <= '0;
		end else begin
			out_l <= pick(sel_l, in_l, in_r, in_u);
			out_r <= pick(sel_r, in_l, in_r, in_u);
			out_u <= pick(sel_u, in_l, in_r, in_u);
		end
	end

	assign {left_link.down_valid, left_link.down_dest, left_link.down_payload} = out_l;
	assign {right_link.down_valid, right_link.down_dest, right_link.down_payload} = out_r;
	assign {parent_link.up_valid, parent_link.up_dest, parent_link.up_payload} = out_u;

	// deflection keeps every packet, so the count of valid words holds across the stage
	a_conserve: assert property (@(posedge clk) disable iff (reset)
		$past(!reset) |->
			$countones({out_l[PKT_W-1], out_r[PKT_W-1], out_u[PKT_W-1]}) ==
			$past($countones({in_l[PKT_W-1], in_r[PKT_W-1], in_u[PKT_W-1]})))
		else $error("packet count changed across %m");

endmodule

// ==== rtl/leaf_port.sv ====
`timescale 1ns/100ps

module leaf_port import bft_pkg::*; #(
	parameter int unsigned LEAF_ADDR = 0
) (
	input  logic       clk,
	input  logic       reset,
	tree_link_if.child link,
	input  logic       inject_valid_i,
	input  leaf_addr_t inject_dest_i,
	input  payload_t   inject_payload_i,
	output logic       deliver_valid_o,
	output leaf_addr_t deliver_dest_o,
	output payload_t   deliver_payload_o,
	output logic       resend_o
);

	logic accept;
	logic passing;

	assign accept  = link.down_valid && (link.down_dest == leaf_addr_t'(LEAF_ADDR));
	// a deflected packet owns the up slot this cycle
	assign passing = link.down_valid && !accept;

	assign resend_o = passing;

	always_ff @(posedge clk) begin
		if (reset) begin
			deliver_valid_o   <= 1'b0;
			deliver_dest_o    <= '0;
			deliver_payload_o <= '0;
			link.up_valid     <= 1'b0;
			link.up_dest      <= '0;
			link.up_payload   <= '0;
		end else begin
			deliver_valid_o   <= accept;
			deliver_dest_o    <= accept ? link.down_dest : '0;
			deliver_payload_o <= accept ? link.down_payload : '0;

			// bounce the passing packet, injection waits for a retry
			if (passing) begin
				link.up_valid   <= 1'b1;
				link.up_dest    <= link.down_dest;
				link.up_payload <= link.down_payload;
			end else begin
				link.up_valid   <= inject_valid_i;
				link.up_dest    <= inject_dest_i;
				link.up_payload <= inject_payload_i;
			end
		end
	end

endmodule

// ==== rtl/bft_top.sv ====
`timescale 1ns/100ps
`include "bft_cfg.svh"

module bft_top import bft_pkg::*; (
	input  logic                                clk,
	input  logic                                reset,
	input  logic       [`BFT_NUM_LEAVES-1:0]   inject_valid_i,
	input  leaf_addr_t [`BFT_NUM_LEAVES-1:0]   inject_dest_i,
	input  payload_t   [`BFT_NUM_LEAVES-1:0]   inject_payload_i,
	output logic       [`BFT_NUM_LEAVES-1:0]   deliver_valid_o,
	output leaf_addr_t [`BFT_NUM_LEAVES-1:0]   deliver_dest_o,
	output payload_t   [`BFT_NUM_LEAVES-1:0]   deliver_payload_o,
	output logic       [`BFT_NUM_LEAVES-1:0]   resend_o
);

	// heap numbering: link h feeds node h from its parent
	// 1 is the stub above the root, 2..7 join switches, 8..15 reach the leaves
	tree_link_if link [1:2*`BFT_NUM_LEAVES-1] ();

	// nothing sits above the root
	assign link[1].down_valid   = 1'b0;
	assign link[1].down_dest    = '0;
	assign link[1].down_payload = '0;

	generate
		for (genvar lvl = 0; lvl < `BFT_LEVELS; lvl++) begin : g_lvl
			for (genvar n = 0; n < (1 << lvl); n++) begin : g_node
				t_switch #(
					.LEVEL     (lvl),
					.NODE_ADDR (n)
				) sw_i (
					.clk         (clk),
					.reset       (reset),
					.parent_link (link[(1 << lvl) + n]),
					.left_link   (link[2 * ((1 << lvl) + n)]),
					.right_link  (link[2 * ((1 << lvl) + n) + 1])
				);
			end
		end

		for (genvar k = 0; k < `BFT_NUM_LEAVES; k++) begin : g_leaf
			leaf_port #(
				.LEAF_ADDR (k)
			) leaf_i (
				.clk               (clk),
				.reset             (reset),
				.link              (link[`BFT_NUM_LEAVES + k]),
				.inject_valid_i    (inject_valid_i[k]),
				.inject_dest_i     (inject_dest_i[k]),
				.inject_payload_i  (inject_payload_i[k]),
				.deliver_valid_o   (deliver_valid_o[k]),
				.deliver_dest_o    (deliver_dest_o[k]),
				.deliver_payload_o (deliver_payload_o[k]),
				.resend_o          (resend_o[k])
			);
		end
	endgenerate

endmodule

// ==== dv/bft_tb.sv ====
`timescale 1ns/100ps
`include "bft_cfg.svh"

module bft_tb import bft_pkg::*; ();

	localparam int N            = `BFT_NUM_LEAVES;
	localparam int CLK_PERIOD   = 10;
	localparam int BULK_PER_LEAF = 20;
	localparam int HOT_PER_LEAF = 10;
	localparam int DRAIN_LIMIT  = 500;
	localparam int TOTAL_PKTS   = N * N + N + N * BULK_PER_LEAF + N * HOT_PER_LEAF;
	localparam int WATCHDOG_CYCLES = TOTAL_PKTS * 64 + 1000;

	logic                 clk;
	logic                 reset;
	logic       [N-1:0]   inject_valid;
	leaf_addr_t [N-1:0]   inject_dest;
	payload_t   [N-1:0]   inject_payload;
	logic       [N-1:0]   deliver_valid;
	leaf_addr_t [N-1:0]   deliver_dest;
	payload_t   [N-1:0]   deliver_payload;
	logic       [N-1:0]   resend;

	// scoreboard indexed by the payload tag
	leaf_addr_t exp_dest [256];
	int         exp_src [256];
	bit         in_flight [256];

	logic [31:0] lfsr = 32'h5702;
	int errors = 0;
	int decoys_seen = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int resend_hits;

	bft_top dut_i (
		.clk               (clk),
		.reset             (reset),
		.inject_valid_i    (inject_valid),
		.inject_dest_i     (inject_dest),
		.inject_payload_i  (inject_payload),
		.deliver_valid_o   (deliver_valid),
		.deliver_dest_o    (deliver_dest),
		.deliver_payload_o (deliver_payload),
		.resend_o          (resend)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp) begin
			$display("FAIL %0t: %s (got %0d, expected %0d)", $time, msg, got, exp);
			errors++;
		end
	endtask

	// level of the lowest switch above both leaves, counted down from the root
	function automatic int lca_level(input int src, input int dst);
		int  k;
		bit  split;
		k = 0;
		split = 1'b0;
		for (int b = `BFT_ADDR_W - 1; b > 0; b--) begin
			if (src[b] != dst[b])
				split = 1'b1;
			if (!split)
				k++;
		end
		return k;
	endfunction

	task automatic expect_packet(input int src, input leaf_addr_t dst, input int tag);
		if (in_flight[tag]) begin
			$display("tag %0d was reused while still in flight at %0t", tag, $time);
			errors++;
		end
		exp_dest[tag]  = dst;
		exp_src[tag]   = src;
		in_flight[tag] = 1'b1;
	endtask

	function automatic int count_in_flight();
		int c;
		c = 0;
		for (int t = 0; t < 256; t++)
			c += int'(in_flight[t]);
		return c;
	endfunction

	// called at a falling edge where the registered outputs are stable
	task automatic check_deliveries();
		payload_t tag;
		for (int l = 0; l < N; l++) begin
			if (deliver_valid[l]) begin
				tag = deliver_payload[l];
				check(32'(deliver_dest[l]), 32'(l), $sformatf("dest field at leaf %0d", l));
				if (in_flight[tag]) begin
					check(32'(exp_dest[tag]), 32'(l),
						$sformatf("arrival leaf of tag %0d from leaf %0d", tag, exp_src[tag]));
					in_flight[tag] = 1'b0;
				end else if (tag >= 8'hF8) begin
					$display("an injection refused by resend reached leaf %0d at %0t", l, $time);
					decoys_seen++;
					errors++;
				end else begin
					$display("leaf %0d got tag %0d that was not in flight at %0t", l, tag, $time);
					errors++;
				end
			end
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errs_before);
		end
	endtask

	task automatic send_single(input int src, input int dst, input int tag);
		int hops;
		int cycles;
		bit seen;
		hops = 2 * (`BFT_LEVELS - 1 - lca_level(src, dst)) + 1;
		@(negedge clk);
		check(32'(resend), 0, "resend on an idle network");
		inject_valid[src]   = 1'b1;
		inject_dest[src]    = leaf_addr_t'(dst);
		inject_payload[src] = payload_t'(tag);
		expect_packet(src, leaf_addr_t'(dst), tag);
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < 40) begin
			@(posedge clk);
			cycles++;
			@(negedge clk);
			inject_valid = '0;
			check(32'(resend), 0, "resend while a lone packet travels");
			if (|deliver_valid) begin
				seen = 1'b1;
				// leaf register, one stage per switch hop, then the deliver register
				check(32'(cycles), 32'(hops + 2), $sformatf("latency %0d to %0d", src, dst));
				check(32'($countones(deliver_valid)), 1, "number of delivering leaves");
				check_deliveries();
			end
		end
		if (!seen) begin
			$display("packet from leaf %0d to leaf %0d never arrived", src, dst);
			errors++;
		end
	endtask

	task automatic run_traffic(input int per_leaf, input bit hot, output int hits);
		logic [N-1:0] pend;
		leaf_addr_t   pend_dest [N];
		int           sent [N];
		int           tag_next;
		int           waited;
		tag_next = 0;
		hits = 0;
		for (int l = 0; l < N; l++) begin
			sent[l] = 0;
			pend[l] = 1'b1;
			pend_dest[l] = hot ? leaf_addr_t'(rand_bits(1)) : leaf_addr_t'(rand_bits(3));
		end
		while (|pend) begin
			@(negedge clk);
			check_deliveries();
			for (int l = 0; l < N; l++) begin
				if (!pend[l]) begin
					inject_valid[l] = 1'b0;
				end else if (resend[l]) begin
					// refused this cycle, so drive a stray tag that must never arrive
					inject_valid[l]   = 1'b1;
					inject_dest[l]    = leaf_addr_t'(rand_bits(3));
					inject_payload[l] = payload_t'(8'hF8 + l);
					hits++;
				end else begin
					inject_valid[l]   = 1'b1;
					inject_dest[l]    = pend_dest[l];
					inject_payload[l] = payload_t'(tag_next);
					expect_packet(l, pend_dest[l], tag_next);
					tag_next++;
					sent[l]++;
					if (sent[l] < per_leaf)
						pend_dest[l] = hot ? leaf_addr_t'(rand_bits(1)) : leaf_addr_t'(rand_bits(3));
					else
						pend[l] = 1'b0;
				end
			end
		end
		// let the last packets land
		waited = 0;
		while (count_in_flight() != 0 && waited < DRAIN_LIMIT) begin
			@(negedge clk);
			inject_valid = '0;
			check_deliveries();
			waited++;
		end
		// nothing more may show up
		repeat (30) begin
			@(negedge clk);
			check_deliveries();
		end
		check(32'(count_in_flight()), 0, "packets still in flight after the drain");
	endtask

	initial begin
		int errs;
		reset          = 1'b1;
		inject_valid   = '0;
		inject_dest    = '0;
		inject_payload = '0;
		for (int t = 0; t < 256; t++)
			in_flight[t] = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		errs = errors;
		repeat (20) begin
			@(negedge clk);
			check(32'(deliver_valid), 0, "deliver_valid after reset");
			check(32'(resend), 0, "resend after reset");
		end
		report_test("idle after reset", errs);

		errs = errors;
		for (int s = 0; s < N; s++)
			for (int d = 0; d < N; d++)
				send_single(s, d, s * N + d);
		report_test("single packets, all pairs", errs);

		errs = errors;
		for (int s = 0; s < N; s++)
			send_single(s, s, 100 + s);
		report_test("self-addressed packets", errs);

		errs = errors;
		run_traffic(BULK_PER_LEAF, 1'b0, resend_hits);
		report_test("random heavy traffic", errs);
		$display("  %0d refused injections during heavy traffic", resend_hits);

		errs = errors;
		run_traffic(HOT_PER_LEAF, 1'b1, resend_hits);
		check(32'(resend_hits > 0), 1, "resend raised under hotspot traffic");
		check(32'(decoys_seen), 0, "refused injections delivered");
		report_test("resend and retry", errs);

		$display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+rtl
rtl/bft_pkg.sv
rtl/tree_link_if.sv
rtl/t_arbiter.sv
rtl/t_switch.sv
rtl/leaf_port.sv
rtl/bft_top.sv
dv/bft_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the fat-tree testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module bft_tb -o bft_sim \
	> build.log 2>&1 \
	&& ./obj_dir/bft_sim > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -qx "Simulation passed" sim.log \
	&& echo "run ok" \
	|| { echo "run failed, see sim.log"; exit 1; }
